// File: common/dcq_consts.svh
// width, queue depth and stall threshold macros for the request queues
`ifndef DCQ_CONSTS_SVH
`define DCQ_CONSTS_SVH

// field widths
`define DCQ_ADDR_W 37 // physical line address
`define DCQ_REQ_W 5
`define DCQ_CTRL_W 5
`define DCQ_DATA_W 64 // single store lane

// queue depths need not be powers of two
`define DCQ_STORE_DEPTH 20
`define DCQ_READ_DEPTH 20
`define DCQ_CODE_DEPTH 8
`define DCQ_MISS_DEPTH 28

// store queue fill level that raises the stall hint
`define DCQ_STALL_CNT 12

`endif

// File: common/dcq_pkg.sv
// payload, ring bus and cache port types of the request queue front end
`include "dcq_consts.svh"

package dcq_pkg;

  typedef logic [`DCQ_ADDR_W-1:0] addr_t;
  typedef logic [`DCQ_REQ_W-1:0] req_id_t;
  typedef logic [`DCQ_CTRL_W-1:0] ctrl_id_t;

  typedef struct packed {
    addr_t addr;
    logic [`DCQ_DATA_W-1:0] data;
    logic [`DCQ_DATA_W/8-1:0] be; // byte enables
  } store_op_t;

  typedef struct packed {
    addr_t addr;
    req_id_t req;
    logic dupl;
    logic want_excl;
  } read_req_t;

  typedef struct packed {
    addr_t addr;
    req_id_t req;
  } code_req_t;

  typedef struct packed {
    addr_t addr;
    req_id_t req;
    logic dupl;
    logic want_excl;
    logic code; // miss came from a code read
  } miss_req_t;

  typedef struct packed {
    ctrl_id_t src_ctrl;
    req_id_t src_req;
    addr_t addr;
    logic want_excl;
    logic dupl;
    logic code;
  } bus_req_t;

  typedef struct packed {
    logic used;
    ctrl_id_t dst_ctrl;
    req_id_t dst_req;
  } bus_reply_t;

  typedef enum logic [1:0] {
    kind_insert,
    kind_data_read,
    kind_code_read,
    kind_store
  } port_kind_t;

  typedef struct packed {
    logic valid;
    port_kind_t kind;
    addr_t addr;
    req_id_t req;
    logic dupl;
    logic want_excl;
    logic [`DCQ_DATA_W-1:0] data;
    logic [`DCQ_DATA_W/8-1:0] be;
  } cache_port_t;

  // line fill formed from a bus reply
  typedef struct packed {
    logic valid;
    addr_t addr;
    req_id_t req;
    logic dupl;
  } insert_t;

endpackage

// File: verilog/dcq_queue.sv
// RAM based FIFO with wrapping pointers and an occupancy counter
`timescale 1ns/1ps

module dcq_queue #(
  parameter type payload_t = logic,
  parameter int DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  payload_t push_data,
  input  logic pop,
  output payload_t head,
  output logic nonempty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // pointers wrap at DEPTH-1 for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign head = mem[rd_ptr];
  assign nonempty = (count != '0);

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr); // head retires
      if (push && !pop)
        count <= count + CNT_W'(1);
      else if (pop && !push)
        count <= count - CNT_W'(1);
    end
  end

endmodule

// File: verilog/dcq_miss_table.sv
// miss address table indexed by request id, reply filter and insert register
`timescale 1ns/1ps
`include "dcq_consts.svh"

module dcq_miss_table #(
  parameter dcq_pkg::ctrl_id_t CTRL_ID = '0
) (
  input  logic clk,
  input  logic rst,
  input  logic miss_push,
  input  dcq_pkg::miss_req_t miss_data,
  input  dcq_pkg::bus_reply_t reply,
  output dcq_pkg::insert_t insert
);

  localparam int ENTRIES = 1 << `DCQ_REQ_W;

  dcq_pkg::addr_t addr_mem [ENTRIES];
  logic dupl_mem [ENTRIES];

  logic hit_q;
  dcq_pkg::addr_t addr_q;
  dcq_pkg::req_id_t req_q;
  logic dupl_q;

  always_ff @(posedge clk)
  begin
    if (miss_push)
    begin
      addr_mem[miss_data.req] <= miss_data.addr;
      dupl_mem[miss_data.req] <= miss_data.dupl;
    end
    addr_q <= addr_mem[reply.dst_req]; // old entry on same-id write
    dupl_q <= dupl_mem[reply.dst_req];
    req_q <= reply.dst_req;
    if (rst)
      hit_q <= 1'b0;
    else
      hit_q <= reply.used && (reply.dst_ctrl == CTRL_ID); // only our replies
  end

  assign insert = '{valid: hit_q, addr: addr_q, req: req_q, dupl: dupl_q};

endmodule

// File: verilog/dcq_port_arbiter.sv
// fixed priority cache port arbiter with queue pops and registered port output
`timescale 1ns/1ps

module dcq_port_arbiter (
  input  logic clk,
  input  logic rst,
  input  logic port_ready,
  input  dcq_pkg::store_op_t st_head,
  input  logic st_nonempty,
  input  dcq_pkg::read_req_t rd_head,
  input  logic rd_nonempty,
  input  dcq_pkg::code_req_t cd_head,
  input  logic cd_nonempty,
  input  dcq_pkg::insert_t insert,
  output logic st_pop,
  output logic rd_pop,
  output logic cd_pop,
  output dcq_pkg::cache_port_t port_out
);

  logic queue_slot;
  dcq_pkg::cache_port_t next_port;

  // insert wins even without port_ready
  assign queue_slot = port_ready && !insert.valid;

  assign rd_pop = queue_slot && rd_nonempty;
  assign cd_pop = queue_slot && !rd_nonempty && cd_nonempty;
  assign st_pop = queue_slot && !rd_nonempty && !cd_nonempty && st_nonempty;

  always_comb
  begin
    next_port = '0;
    if (insert.valid)
    begin
      next_port.valid = 1'b1;
      next_port.kind = dcq_pkg::kind_insert;
      next_port.addr = insert.addr;
      next_port.req = insert.req;
      next_port.dupl = insert.dupl;
    end
    else if (rd_pop)
    begin
      next_port.valid = 1'b1;
      next_port.kind = dcq_pkg::kind_data_read;
      next_port.addr = rd_head.addr;
      next_port.req = rd_head.req;
      next_port.dupl = rd_head.dupl;
      next_port.want_excl = rd_head.want_excl;
    end
    else if (cd_pop)
    begin
      next_port.valid = 1'b1;
      next_port.kind = dcq_pkg::kind_code_read;
      next_port.addr = cd_head.addr;
      next_port.req = cd_head.req;
    end
    else if (st_pop)
    begin
      next_port.valid = 1'b1;
      next_port.kind = dcq_pkg::kind_store;
      next_port.addr = st_head.addr;
      next_port.data = st_head.data;
      next_port.be = st_head.be;
    end
  end

  always_ff @(posedge clk)
  begin
    port_out <= next_port;
    if (rst)
      port_out.valid <= 1'b0;
  end

endmodule

// File: verilog/dcq_top.sv
// request queue front end top with the four queues, miss table, arbiter and stall hint
`timescale 1ns/1ps
`include "dcq_consts.svh"

module dcq_top #(
  parameter dcq_pkg::ctrl_id_t CTRL_ID = '0
) (
  input  logic clk,
  input  logic rst,
  input  logic store_push,
  input  dcq_pkg::store_op_t store_data,
  input  logic read_push,
  input  dcq_pkg::read_req_t read_data,
  input  logic code_push,
  input  dcq_pkg::code_req_t code_data,
  input  logic miss_push,
  input  dcq_pkg::miss_req_t miss_data,
  input  logic port_ready,
  input  logic bus_can,
  input  dcq_pkg::bus_reply_t bus_reply,
  output dcq_pkg::cache_port_t port_out,
  output logic bus_want,
  output dcq_pkg::bus_req_t bus_req,
  output logic stall_hint
);

  localparam int ST_CNT_W = $clog2(`DCQ_STORE_DEPTH + 1);

  dcq_pkg::store_op_t st_head;
  dcq_pkg::read_req_t rd_head;
  dcq_pkg::code_req_t cd_head;
  dcq_pkg::miss_req_t miss_head;
  logic st_nonempty, rd_nonempty, cd_nonempty;
  logic st_pop, rd_pop, cd_pop;
  logic [ST_CNT_W-1:0] st_count;
  dcq_pkg::insert_t insert;

  dcq_queue #(.payload_t(dcq_pkg::store_op_t), .DEPTH(`DCQ_STORE_DEPTH)) i_store_q (
    .clk(clk), .rst(rst), .push(store_push), .push_data(store_data), .pop(st_pop),
    .head(st_head), .nonempty(st_nonempty), .count(st_count)
  );

  dcq_queue #(.payload_t(dcq_pkg::read_req_t), .DEPTH(`DCQ_READ_DEPTH)) i_read_q (
    .clk(clk), .rst(rst), .push(read_push), .push_data(read_data), .pop(rd_pop),
    .head(rd_head), .nonempty(rd_nonempty), .count()
  );

  dcq_queue #(.payload_t(dcq_pkg::code_req_t), .DEPTH(`DCQ_CODE_DEPTH)) i_code_q (
    .clk(clk), .rst(rst), .push(code_push), .push_data(code_data), .pop(cd_pop),
    .head(cd_head), .nonempty(cd_nonempty), .count()
  );

  // miss head leaves on a want/can transfer
  dcq_queue #(.payload_t(dcq_pkg::miss_req_t), .DEPTH(`DCQ_MISS_DEPTH)) i_miss_q (
    .clk(clk), .rst(rst), .push(miss_push), .push_data(miss_data),
    .pop(bus_want && bus_can), .head(miss_head), .nonempty(bus_want), .count()
  );

  dcq_miss_table #(.CTRL_ID(CTRL_ID)) i_miss_table (
    .clk(clk),
    .rst(rst),
    .miss_push(miss_push),
    .miss_data(miss_data),
    .reply(bus_reply),
    .insert(insert)
  );

  dcq_port_arbiter i_arbiter (
    .clk(clk), .rst(rst), .port_ready(port_ready),
    .st_head(st_head), .st_nonempty(st_nonempty),
    .rd_head(rd_head), .rd_nonempty(rd_nonempty),
    .cd_head(cd_head), .cd_nonempty(cd_nonempty),
    .insert(insert),
    .st_pop(st_pop), .rd_pop(rd_pop), .cd_pop(cd_pop),
    .port_out(port_out)
  );

  always_comb
  begin
    bus_req.src_ctrl = CTRL_ID;
    bus_req.src_req = miss_head.req;
    bus_req.addr = miss_head.addr;
    bus_req.want_excl = miss_head.want_excl;
    bus_req.dupl = miss_head.dupl;
    bus_req.code = miss_head.code;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      stall_hint <= 1'b0;
    else
      stall_hint <= (st_count >= ST_CNT_W'(`DCQ_STALL_CNT)); // one cycle late
  end

endmodule

// File: testbench/dcq_assertions.sv
// concurrent FIFO protocol assertions, bound into every dcq_queue
`timescale 1ns/1ps

module dcq_assertions #(
  parameter int DEPTH = 4
) (
  input logic clk,
  input logic rst,
  input logic push,
  input logic pop,
  input logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

  int fail_count = 0; // failed checks so far

  no_push_when_full: assert property (@(posedge clk) disable iff (rst) !(push && count == FULL))
  else
  begin
    fail_count++;
    $error("push into a full queue of depth %0d", DEPTH);
  end

  no_pop_when_empty: assert property (@(posedge clk) disable iff (rst) !(pop && count == '0))
  else
  begin
    fail_count++;
    $error("pop from an empty queue of depth %0d", DEPTH);
  end

  count_in_range: assert property (@(posedge clk) disable iff (rst) count <= FULL)
  else
  begin
    fail_count++;
    $error("queue count %0d above depth %0d", count, DEPTH);
  end

endmodule

bind dcq_queue dcq_assertions #(.DEPTH(DEPTH)) i_queue_checks (
  .clk(clk),
  .rst(rst),
  .push(push),
  .pop(pop),
  .count(count)
);

// File: testbench/dcq_tb.sv
// testbench for the request queue front end with compare tasks and directed tests
`timescale 1ns/1ps
`include "dcq_consts.svh"

module dcq_tb;

  localparam dcq_pkg::ctrl_id_t CTRL_ID = 5'd3;
  localparam int WAIT_LIMIT = 60;

  logic clk;
  logic rst;
  logic store_push;
  dcq_pkg::store_op_t store_data;
  logic read_push;
  dcq_pkg::read_req_t read_data;
  logic code_push;
  dcq_pkg::code_req_t code_data;
  logic miss_push;
  dcq_pkg::miss_req_t miss_data;
  logic port_ready;
  logic bus_can;
  dcq_pkg::bus_reply_t bus_reply;
  dcq_pkg::cache_port_t port_out;
  logic bus_want;
  dcq_pkg::bus_req_t bus_req;
  logic stall_hint;

  int mismatch_count = 0;
  int other_errors = 0;
  logic [31:0] lfsr_state = 32'h8975_1a65;
  dcq_pkg::cache_port_t port_seen[$];
  dcq_pkg::bus_req_t bus_seen[$];

  dcq_top #(.CTRL_ID(CTRL_ID)) i_dut (
    .clk(clk), .rst(rst),
    .store_push(store_push), .store_data(store_data),
    .read_push(read_push), .read_data(read_data),
    .code_push(code_push), .code_data(code_data),
    .miss_push(miss_push), .miss_data(miss_data),
    .port_ready(port_ready), .bus_can(bus_can), .bus_reply(bus_reply),
    .port_out(port_out), .bus_want(bus_want), .bus_req(bus_req), .stall_hint(stall_hint)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // mid-cycle capture of port outputs and bus transfers
  always @(negedge clk)
  begin
    if (!rst && port_out.valid)
      port_seen.push_back(port_out);
    if (!rst && bus_want && bus_can)
      bus_seen.push_back(bus_req);
  end

  // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic dcq_pkg::store_op_t rand_store();
    dcq_pkg::store_op_t op;
    op.addr = dcq_pkg::addr_t'(rand_bits(`DCQ_ADDR_W));
    op.data = rand_bits(`DCQ_DATA_W);
    op.be = 8'(rand_bits(8));
    return op;
  endfunction

  // expected port word with absent fields at zero
  function automatic dcq_pkg::cache_port_t make_port(input dcq_pkg::port_kind_t kind,
      input dcq_pkg::addr_t addr, input dcq_pkg::req_id_t req, input logic dupl,
      input logic want_excl, input logic [63:0] data, input logic [7:0] be);
    dcq_pkg::cache_port_t p;
    p.valid = 1'b1;
    p.kind = kind;
    p.addr = addr;
    p.req = req;
    p.dupl = dupl;
    p.want_excl = want_excl;
    p.data = data;
    p.be = be;
    return p;
  endfunction

  function automatic dcq_pkg::bus_req_t bus_from_miss(input dcq_pkg::miss_req_t m);
    dcq_pkg::bus_req_t b;
    b.src_ctrl = CTRL_ID;
    b.src_req = m.req;
    b.addr = m.addr;
    b.want_excl = m.want_excl;
    b.dupl = m.dupl;
    b.code = m.code;
    return b;
  endfunction

  task automatic check_port(input string name, input dcq_pkg::cache_port_t got,
      input dcq_pkg::cache_port_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got=%h exp=%h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_bus(input string name, input dcq_pkg::bus_req_t got,
      input dcq_pkg::bus_req_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got=%h exp=%h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got=%h exp=%h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic expect_port(input dcq_pkg::cache_port_t exp, input string what);
    int waited;
    waited = 0;
    while (port_seen.size() == 0 && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (port_seen.size() == 0)
    begin
      $display("timed out waiting for the %s on the cache port", what);
      other_errors++;
    end
    else
      check_port(what, port_seen.pop_front(), exp);
  endtask

  task automatic expect_bus(input dcq_pkg::bus_req_t exp, input string what);
    int waited;
    waited = 0;
    while (bus_seen.size() == 0 && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (bus_seen.size() == 0)
    begin
      $display("timed out waiting for the %s on the bus", what);
      other_errors++;
    end
    else
      check_bus(what, bus_seen.pop_front(), exp);
  endtask

  task automatic expect_quiet(input int cycles, input string what);
    repeat (cycles) @(posedge clk);
    if (port_seen.size() != 0)
    begin
      $display("cache port output appeared where none was due: %s", what);
      other_errors++;
      port_seen.delete();
    end
  endtask

  task automatic push_store(input dcq_pkg::store_op_t op);
    @(posedge clk);
    store_push <= 1'b1;
    store_data <= op;
    @(posedge clk);
    store_push <= 1'b0;
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_flag("port_out.valid", port_out.valid, 1'b0);
    check_flag("bus_want", bus_want, 1'b0);
    check_flag("stall_hint", stall_hint, 1'b0);
  endtask

  task automatic test_store_order();
    dcq_pkg::store_op_t ops[6];
    for (int i = 0; i < 6; i++)
      ops[i] = rand_store();
    @(posedge clk);
    port_ready <= 1'b1;
    for (int i = 0; i < 6; i++)
      push_store(ops[i]);
    for (int i = 0; i < 6; i++)
      expect_port(make_port(dcq_pkg::kind_store, ops[i].addr, '0, 1'b0, 1'b0,
                            ops[i].data, ops[i].be), "store");
  endtask

  task automatic test_priority();
    dcq_pkg::store_op_t st;
    dcq_pkg::read_req_t rd;
    dcq_pkg::code_req_t cd;
    st = rand_store();
    rd.addr = dcq_pkg::addr_t'(rand_bits(`DCQ_ADDR_W));
    rd.req = dcq_pkg::req_id_t'(rand_bits(`DCQ_REQ_W));
    rd.dupl = 1'b1;
    rd.want_excl = 1'b1;
    cd.addr = dcq_pkg::addr_t'(rand_bits(`DCQ_ADDR_W));
    cd.req = dcq_pkg::req_id_t'(rand_bits(`DCQ_REQ_W));
    @(posedge clk);
    port_ready <= 1'b0;
    store_push <= 1'b1;
    store_data <= st;
    read_push <= 1'b1;
    read_data <= rd;
    code_push <= 1'b1;
    code_data <= cd;
    @(posedge clk);
    store_push <= 1'b0;
    read_push <= 1'b0;
    code_push <= 1'b0;
    expect_quiet(4, "queues held while port_ready is low");
    @(posedge clk);
    port_ready <= 1'b1;
    expect_port(make_port(dcq_pkg::kind_data_read, rd.addr, rd.req, rd.dupl, rd.want_excl,
                          '0, '0), "data read");
    expect_port(make_port(dcq_pkg::kind_code_read, cd.addr, cd.req, 1'b0, 1'b0, '0, '0),
                "code read");
    expect_port(make_port(dcq_pkg::kind_store, st.addr, '0, 1'b0, 1'b0, st.data, st.be),
                "store");
  endtask

  task automatic test_bus_backpressure();
    dcq_pkg::miss_req_t m[3];
    for (int i = 0; i < 3; i++)
    begin
      m[i].addr = dcq_pkg::addr_t'(rand_bits(`DCQ_ADDR_W));
      m[i].req = dcq_pkg::req_id_t'(rand_bits(`DCQ_REQ_W));
      m[i].dupl = 1'(rand_bits(1));
      m[i].want_excl = 1'(rand_bits(1));
      m[i].code = 1'(rand_bits(1));
    end
    @(posedge clk);
    bus_can <= 1'b0;
    for (int i = 0; i < 3; i++)
    begin
      @(posedge clk);
      miss_push <= 1'b1;
      miss_data <= m[i];
    end
    @(posedge clk);
    miss_push <= 1'b0;
    repeat (3)
    begin
      @(negedge clk);
      check_flag("bus_want", bus_want, 1'b1);
      check_bus("bus_req", bus_req, bus_from_miss(m[0])); // head holds
    end
    @(posedge clk);
    bus_can <= 1'b1;
    for (int i = 0; i < 3; i++)
      expect_bus(bus_from_miss(m[i]), "bus_req transfer");
    @(posedge clk);
    bus_can <= 1'b0;
    @(negedge clk);
    check_flag("bus_want", bus_want, 1'b0);
  endtask

  task automatic test_reply_insert();
    dcq_pkg::miss_req_t m;
    dcq_pkg::bus_reply_t rep;
    m.addr = dcq_pkg::addr_t'(rand_bits(`DCQ_ADDR_W));
    m.req = dcq_pkg::req_id_t'(rand_bits(`DCQ_REQ_W));
    m.dupl = 1'b1;
    m.want_excl = 1'b0;
    m.code = 1'b0;
    rep.used = 1'b1;
    rep.dst_ctrl = CTRL_ID;
    rep.dst_req = m.req;
    @(posedge clk);
    port_ready <= 1'b0;
    miss_push <= 1'b1;
    miss_data <= m;
    @(posedge clk);
    miss_push <= 1'b0;
    @(posedge clk);
    bus_reply <= rep;
    @(posedge clk);
    bus_reply <= '0;
    @(negedge clk);
    check_flag("port_out.valid", port_out.valid, 1'b0);
    @(negedge clk);
    check_port("port_out", port_out,
               make_port(dcq_pkg::kind_insert, m.addr, m.req, m.dupl, 1'b0, '0, '0));
    @(posedge clk);
    if (port_seen.size() != 1)
    begin
      $display("expected exactly one insert on the cache port, saw %0d", port_seen.size());
      other_errors++;
    end
    port_seen.delete();
    rep.dst_ctrl = 5'd4; // someone else's reply
    bus_reply <= rep;
    @(posedge clk);
    bus_reply <= '0;
    expect_quiet(5, "insert for another controller");
  endtask

  task automatic test_stall_hint();
    dcq_pkg::store_op_t ops[12];
    @(posedge clk);
    port_ready <= 1'b0;
    for (int i = 0; i < 11; i++)
    begin
      ops[i] = rand_store();
      push_store(ops[i]);
      @(negedge clk);
      check_flag("stall_hint", stall_hint, 1'b0);
    end
    repeat (2) @(negedge clk);
    check_flag("stall_hint", stall_hint, 1'b0);
    ops[11] = rand_store();
    push_store(ops[11]);
    @(negedge clk);
    check_flag("stall_hint", stall_hint, 1'b0);
    @(negedge clk);
    check_flag("stall_hint", stall_hint, 1'b1);
    repeat (3) @(negedge clk);
    check_flag("stall_hint", stall_hint, 1'b1);
    @(posedge clk);
    port_ready <= 1'b1;
    repeat (2) @(negedge clk);
    check_flag("stall_hint", stall_hint, 1'b1); // count still 12 when sampled
    @(negedge clk);
    check_flag("stall_hint", stall_hint, 1'b0);
    for (int i = 0; i < 12; i++)
      expect_port(make_port(dcq_pkg::kind_store, ops[i].addr, '0, 1'b0, 1'b0,
                            ops[i].data, ops[i].be), "drained store");
  endtask

  initial
  begin
    int assert_fails;
    rst <= 1'b1;
    store_push <= 1'b0;
    store_data <= '0;
    read_push <= 1'b0;
    read_data <= '0;
    code_push <= 1'b0;
    code_data <= '0;
    miss_push <= 1'b0;
    miss_data <= '0;
    port_ready <= 1'b0;
    bus_can <= 1'b0;
    bus_reply <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_store_order();
    test_priority();
    test_bus_backpressure();
    test_reply_insert();
    test_stall_hint();
    repeat (4) @(posedge clk);
    assert_fails = i_dut.i_store_q.i_queue_checks.fail_count
                 + i_dut.i_read_q.i_queue_checks.fail_count
                 + i_dut.i_code_q.i_queue_checks.fail_count
                 + i_dut.i_miss_q.i_queue_checks.fail_count;
    $display("%0d mismatches, %0d other errors, %0d assertion failures",
             mismatch_count, other_errors, assert_fails);
    if (mismatch_count == 0 && other_errors == 0 && assert_fails == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial
  begin
    #100000;
    $display("simulation did not reach the end of the tests in time");
    $display("Regression failed");
    $finish;
  end

endmodule

// File: dcq_top.f
+incdir+common
common/dcq_pkg.sv
verilog/dcq_queue.sv
verilog/dcq_miss_table.sv
verilog/dcq_port_arbiter.sv
verilog/dcq_top.sv
testbench/dcq_assertions.sv
testbench/dcq_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= dcq_tb
FILELIST ?= dcq_top.f
FLAGS ?= --timing --assert
BUILD_DIR ?= obj_dir
RUN_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
